// File: mtag_pkg.sv
// Tag and hart widths are fixed here because the packed request and entry structs depend on them.
package mtag_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Widths.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Width of a tagged pointer.
    localparam int XLEN = 32;

    // Number of harts sharing the tag memory.
    localparam int HARTS = 2;

    // Width of one tag memory word.
    localparam int TLEN = 16;

    // The tag field fills what the hart mask leaves of a word.
    localparam int PTAG_WIDTH = TLEN - HARTS;

    // Hart index width, never below one bit.
    localparam int HART_ID_WIDTH = (HARTS > 1) ? $clog2(HARTS) : 1;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Types.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Tagged pointer, tag in the top PTAG_WIDTH bits.
    typedef logic [XLEN-1:0] xlen_t;

    // Pointer tag.
    typedef logic [PTAG_WIDTH-1:0] ptag_t;

    // Index of a hart.
    typedef logic [HART_ID_WIDTH-1:0] hart_id_t;

    // One ownership bit per hart.
    typedef logic [HARTS-1:0] hart_mask_t;

    // One tag memory word.
    // Tag sits in the upper bits, the hart mask below it.
    typedef struct packed {
        ptag_t      tag;
        hart_mask_t harts;
    } tag_entry_t;

    // Request as captured from the bus.
    typedef struct packed {
        logic       we;     // Tag store when set, tag check when clear.
        xlen_t      ptr;    // Tagged pointer.
        hart_id_t   hart;   // Requesting hart.
        hart_mask_t mask;   // Ownership mask, only meaningful on a store.
    } mtag_req_t;

endpackage

// File: mtag_decode.sv
// Takes one Wishbone classic request at a time; STB is ignored until the result stage reports done.
`timescale 1ns/1ps

module mtag_decode
    import mtag_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,

    // Wishbone classic slave request side.
    input  logic      wb_cyc_i,
    input  logic      wb_stb_i,
    input  logic      wb_we_i,
    input  xlen_t     wb_adr_i,
    input  xlen_t     wb_dat_i,
    input  hart_id_t  hart_i,

    // End of the current access, from the result stage.
    input  logic      done_i,

    // Decoded request towards the checker.
    output mtag_req_t req_o,
    output logic      req_valid_o
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Request FSM.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic {
        IDLE,
        BUSY
    } state_t;

    state_t state;
    logic   accept;

    // A request is only taken while nothing is in flight.
    assign accept = (state == IDLE) && wb_cyc_i && wb_stb_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state       <= IDLE;
            req_valid_o <= 1'b0;
        end else begin
            // Strobe for the tag memory lasts one cycle.
            req_valid_o <= accept;
            case (state)
                IDLE: begin
                    if (accept) begin
                        state <= BUSY;
                    end
                end
                BUSY: begin
                    // Held here through the ACK or ERR cycle.
                    if (done_i) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Request payload.
    // Stays stable while BUSY so that later stages can read it.
    always_ff @(posedge clk_i) begin
        if (accept) begin
            req_o.we   <= wb_we_i;
            req_o.ptr  <= wb_adr_i;
            req_o.hart <= hart_i;
            req_o.mask <= wb_dat_i[HARTS-1:0];
        end
    end

    // The result stage only finishes an access that decode started.
    a_done_only_when_busy: assert property (
        @(posedge clk_i) disable iff (rst_i)
        done_i |-> (state == BUSY)
    );

endmodule

// File: mtag_chk.sv
// Combinational checker; err_o is only meaningful while tmem_ack_i is high and never set on a store.
`timescale 1ns/1ps

module mtag_chk
    import mtag_pkg::*;
#(
    // Granule size as a shift, 2**GRANULARITY bytes per tag.
    parameter int GRANULARITY = 2,
    // Byte address bits that reach the tag memory.
    parameter int ADR_WIDTH = 10,
    localparam int TADR_WIDTH = ADR_WIDTH - GRANULARITY
) (
    // Start of an access, one cycle.
    input  logic                  ena_i,
    input  mtag_req_t             req_i,

    // Tag memory master port.
    output logic                  tmem_re_o,
    output logic                  tmem_we_o,
    output logic [TADR_WIDTH-1:0] tmem_adr_o,
    output tag_entry_t            tmem_dat_o,
    input  tag_entry_t            tmem_dat_i,
    input  logic                  tmem_ack_i,

    // Tag or hart mismatch.
    output logic                  err_o
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pointer fields.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic [ADR_WIDTH-1:0] mem_adr;
    ptag_t                ptr_tag;

    // Low bits address bytes, top bits carry the tag.
    assign mem_adr = req_i.ptr[ADR_WIDTH-1:0];
    assign ptr_tag = req_i.ptr[XLEN-1 -: PTAG_WIDTH];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Tag memory access.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        tmem_re_o  = 1'b0;
        tmem_we_o  = 1'b0;
        tmem_adr_o = '0;
        tmem_dat_o = '0;

        if (ena_i) begin
            // One entry per granule.
            tmem_adr_o = TADR_WIDTH'(mem_adr >> GRANULARITY);
            if (req_i.we) begin
                tmem_we_o        = 1'b1;
                tmem_dat_o.tag   = ptr_tag;
                tmem_dat_o.harts = req_i.mask;
            end else begin
                tmem_re_o = 1'b1;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Check.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Read data is valid only with the acknowledge.
    // The request is still held by decode at that point.
    always_comb begin
        err_o = 1'b0;
        if (tmem_ack_i && !req_i.we) begin
            // Hart ownership first.
            if (!tmem_dat_i.harts[req_i.hart]) begin
                err_o = 1'b1;
            end else if (tmem_dat_i.tag != ptr_tag) begin
                // Then the stored tag against the pointer tag.
                err_o = 1'b1;
            end
        end
    end

endmodule

// File: mtag_store.sv
// Entries are not initialised; a granule must be stored before it is checked.
`timescale 1ns/1ps

module mtag_store
    import mtag_pkg::*;
#(
    parameter int GRANULARITY = 2,
    parameter int ADR_WIDTH = 10,
    localparam int TADR_WIDTH = ADR_WIDTH - GRANULARITY
) (
    input  logic                  clk_i,
    input  logic                  rst_i,

    // Tag memory slave port.
    input  logic                  tmem_re_i,
    input  logic                  tmem_we_i,
    input  logic [TADR_WIDTH-1:0] tmem_adr_i,
    input  tag_entry_t            tmem_dat_i,
    output tag_entry_t            tmem_dat_o,
    output logic                  tmem_ack_o
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Storage.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // One word per granule.
    localparam int DEPTH = 2 ** TADR_WIDTH;

    tag_entry_t mem [DEPTH];

    // Single port, registered read.
    always_ff @(posedge clk_i) begin
        if (tmem_we_i) begin
            mem[tmem_adr_i] <= tmem_dat_i;
        end else if (tmem_re_i) begin
            tmem_dat_o <= mem[tmem_adr_i];
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Acknowledge.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // One cycle, lined up with the read data.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            tmem_ack_o <= 1'b0;
        end else begin
            tmem_ack_o <= tmem_re_i || tmem_we_i;
        end
    end

    // The checker never reads and writes at once.
    a_no_read_write: assert property (
        @(posedge clk_i) disable iff (rst_i)
        !(tmem_re_i && tmem_we_i)
    );

    // The port stays quiet while an acknowledge is out.
    a_no_strobe_during_ack: assert property (
        @(posedge clk_i) disable iff (rst_i)
        tmem_ack_o |-> !(tmem_re_i || tmem_we_i)
    );

endmodule

// File: mtag_result.sv
// ACK or ERR lasts one cycle; only the first fault is recorded, the count saturates at 255.
`timescale 1ns/1ps

module mtag_result
    import mtag_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,

    // From the tag memory and the checker.
    input  logic      tmem_ack_i,
    input  logic      chk_err_i,
    input  mtag_req_t req_i,

    // Wishbone response.
    output logic      wb_ack_o,
    output logic      wb_err_o,

    // Releases decode.
    output logic      done_o,

    // Fault record.
    output logic      fault_valid_o,
    output xlen_t     fault_adr_o,
    output hart_id_t  fault_hart_o,
    output logic [7:0] fault_cnt_o
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus response.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic fault;

    // A mismatch seen with the tag memory acknowledge.
    assign fault = tmem_ack_i && chk_err_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wb_ack_o <= 1'b0;
            wb_err_o <= 1'b0;
            done_o   <= 1'b0;
        end else begin
            wb_ack_o <= tmem_ack_i && !chk_err_i;
            wb_err_o <= fault;
            // Same cycle as the response.
            done_o   <= tmem_ack_i;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Fault record.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Valid flag and fault count.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            fault_valid_o <= 1'b0;
            fault_cnt_o   <= '0;
        end else if (fault) begin
            fault_valid_o <= 1'b1;
            // Saturates.
            if (fault_cnt_o != 8'hff) begin
                fault_cnt_o <= fault_cnt_o + 8'd1;
            end
        end
    end

    // First fault wins.
    // Later faults leave pointer and hart as they are.
    always_ff @(posedge clk_i) begin
        if (fault && !fault_valid_o) begin
            fault_adr_o  <= req_i.ptr;
            fault_hart_o <= req_i.hart;
        end
    end

    // Exactly one response per access, one cycle long.
    a_resp_one_cycle: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (wb_ack_o || wb_err_o) |=> !(wb_ack_o || wb_err_o)
    );

    // A tag store always completes; the checker only flags checks.
    a_store_never_err: assert property (
        @(posedge clk_i) disable iff (rst_i)
        wb_err_o |-> !req_i.we
    );

endmodule

// File: mtag_unit.sv
// Serves one request at a time, ACK or ERR two edges after acceptance; no data memory behind it.
`timescale 1ns/1ps

module mtag_unit
    import mtag_pkg::*;
#(
    parameter int GRANULARITY = 2,
    parameter int ADR_WIDTH = 10
) (
    input  logic       clk_i,
    input  logic       rst_i,

    // Wishbone classic slave.
    input  logic       wb_cyc_i,
    input  logic       wb_stb_i,
    input  logic       wb_we_i,
    input  xlen_t      wb_adr_i,
    input  xlen_t      wb_dat_i,
    output logic       wb_ack_o,
    output logic       wb_err_o,

    // Requesting hart, sampled with the request.
    input  hart_id_t   hart_i,

    // Fault record.
    output logic       fault_valid_o,
    output xlen_t      fault_adr_o,
    output hart_id_t   fault_hart_o,
    output logic [7:0] fault_cnt_o
);

    // Tag memory index width.
    localparam int TADR_WIDTH = ADR_WIDTH - GRANULARITY;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Internal wiring.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    mtag_req_t             req;
    logic                  req_valid;
    logic                  done;
    logic                  chk_err;

    // Tag memory port.
    logic                  tmem_re;
    logic                  tmem_we;
    logic [TADR_WIDTH-1:0] tmem_adr;
    tag_entry_t            tmem_wdat;
    tag_entry_t            tmem_rdat;
    logic                  tmem_ack;

    // Decode, request capture.
    mtag_decode i_decode (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .wb_cyc_i    (wb_cyc_i),
        .wb_stb_i    (wb_stb_i),
        .wb_we_i     (wb_we_i),
        .wb_adr_i    (wb_adr_i),
        .wb_dat_i    (wb_dat_i),
        .hart_i      (hart_i),
        .done_i      (done),
        .req_o       (req),
        .req_valid_o (req_valid)
    );

    // Execute, checker.
    mtag_chk #(
        .GRANULARITY (GRANULARITY),
        .ADR_WIDTH   (ADR_WIDTH)
    ) i_chk (
        .ena_i      (req_valid),
        .req_i      (req),
        .tmem_re_o  (tmem_re),
        .tmem_we_o  (tmem_we),
        .tmem_adr_o (tmem_adr),
        .tmem_dat_o (tmem_wdat),
        .tmem_dat_i (tmem_rdat),
        .tmem_ack_i (tmem_ack),
        .err_o      (chk_err)
    );

    // Execute, tag store.
    mtag_store #(
        .GRANULARITY (GRANULARITY),
        .ADR_WIDTH   (ADR_WIDTH)
    ) i_store (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .tmem_re_i  (tmem_re),
        .tmem_we_i  (tmem_we),
        .tmem_adr_i (tmem_adr),
        .tmem_dat_i (tmem_wdat),
        .tmem_dat_o (tmem_rdat),
        .tmem_ack_o (tmem_ack)
    );

    // Result, bus response and fault record.
    mtag_result i_result (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .tmem_ack_i    (tmem_ack),
        .chk_err_i     (chk_err),
        .req_i         (req),
        .wb_ack_o      (wb_ack_o),
        .wb_err_o      (wb_err_o),
        .done_o        (done),
        .fault_valid_o (fault_valid_o),
        .fault_adr_o   (fault_adr_o),
        .fault_hart_o  (fault_hart_o),
        .fault_cnt_o   (fault_cnt_o)
    );

endmodule

// File: tb_mtag_table.svh
// Directed operations for GRANULARITY 2 and ADR_WIDTH 10; every granule is stored before it is checked.
`ifndef TB_MTAG_TABLE_SVH
`define TB_MTAG_TABLE_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed table.
// Columns: name, we, tag, byte address, hart, mask, expected ERR.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

task automatic build_table();
    // Granule 1, both harts own it.
    add_op("st_g1_both",      1'b1, 14'h00a5, 10'h004, 1'b0, 2'b11, 1'b0);
    add_op("chk_g1_h0",       1'b0, 14'h00a5, 10'h004, 1'b0, 2'b00, 1'b0);
    // Other byte of the same granule, other hart.
    add_op("chk_g1_h1_byte3", 1'b0, 14'h00a5, 10'h007, 1'b1, 2'b00, 1'b0);
    // Tag off by one, first fault of the run.
    add_op("chk_g1_badtag",   1'b0, 14'h00a6, 10'h005, 1'b0, 2'b00, 1'b1);

    // Granule 2, hart 0 only.
    // The storing hart does not matter.
    add_op("st_g2_h0",        1'b1, 14'h1234, 10'h008, 1'b1, 2'b01, 1'b0);
    add_op("chk_g2_h1",       1'b0, 14'h1234, 10'h00a, 1'b1, 2'b00, 1'b1);
    add_op("chk_g2_h0",       1'b0, 14'h1234, 10'h00b, 1'b0, 2'b00, 1'b0);
    // Neighbour granule keeps its own entry.
    add_op("chk_g1_kept",     1'b0, 14'h00a5, 10'h006, 1'b1, 2'b00, 1'b0);

    // Granule 0, hart 1 only, all-ones tag.
    add_op("st_g0_h1",        1'b1, 14'h3fff, 10'h000, 1'b0, 2'b10, 1'b0);
    add_op("chk_g0_h1",       1'b0, 14'h3fff, 10'h003, 1'b1, 2'b00, 1'b0);
    add_op("chk_g0_h0",       1'b0, 14'h3fff, 10'h001, 1'b0, 2'b00, 1'b1);
    // Hart and tag both wrong.
    add_op("chk_g0_both_bad", 1'b0, 14'h0000, 10'h000, 1'b0, 2'b00, 1'b1);

    // Retag granule 1 for hart 1.
    add_op("st_g1_retag",     1'b1, 14'h2001, 10'h004, 1'b0, 2'b10, 1'b0);
    add_op("chk_g1_oldtag",   1'b0, 14'h00a5, 10'h004, 1'b1, 2'b00, 1'b1);
    add_op("chk_g1_newtag",   1'b0, 14'h2001, 10'h005, 1'b1, 2'b00, 1'b0);

    // Last granule of the address range.
    add_op("st_top",          1'b1, 14'h0155, 10'h3ff, 1'b0, 2'b11, 1'b0);
    add_op("chk_top_h0",      1'b0, 14'h0155, 10'h3fc, 1'b0, 2'b00, 1'b0);
    add_op("chk_top_badtag",  1'b0, 14'h0154, 10'h3fd, 1'b1, 2'b00, 1'b1);
endtask

`endif

// File: tb_mtag_unit.sv
// Runs the unit with GRANULARITY 2 and ADR_WIDTH 10; fault count must stay below 255 to be exact.
`timescale 1ns/1ps

module tb_mtag_unit
    import mtag_pkg::*;
();

    localparam int GRANULARITY = 2;
    localparam int ADR_WIDTH   = 10;
    localparam int TADR_WIDTH  = ADR_WIDTH - GRANULARITY;
    // Random store and check pairs.
    localparam int N_RAND      = 24;
    // Cycles to wait for ACK or ERR.
    localparam int RESP_LIMIT  = 8;

    logic       clk;
    logic       rst;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    xlen_t      wb_adr;
    xlen_t      wb_dat;
    logic       wb_ack;
    logic       wb_err;
    hart_id_t   hart;
    logic       fault_valid;
    xlen_t      fault_adr;
    hart_id_t   fault_hart;
    logic [7:0] fault_cnt;

    // Operation table, filled by build_table.
    string                op_name [$];
    logic                 op_we   [$];
    ptag_t                op_tag  [$];
    logic [ADR_WIDTH-1:0] op_adr  [$];
    hart_id_t             op_hart [$];
    hart_mask_t           op_mask [$];
    logic                 op_err  [$];

    // Reference copy of the tag array.
    tag_entry_t model_mem [2**TADR_WIDTH];

    int       mismatch_cnt = 0;
    int       other_cnt    = 0;
    int       exp_faults   = 0;
    logic     have_fault   = 1'b0;
    xlen_t    first_ptr;
    hart_id_t first_hart;
    logic     table_ready  = 1'b0;
    integer   seed         = 32'hf400_d163;

    mtag_unit #(
        .GRANULARITY (GRANULARITY),
        .ADR_WIDTH   (ADR_WIDTH)
    ) i_dut (
        .clk_i         (clk),
        .rst_i         (rst),
        .wb_cyc_i      (wb_cyc),
        .wb_stb_i      (wb_stb),
        .wb_we_i       (wb_we),
        .wb_adr_i      (wb_adr),
        .wb_dat_i      (wb_dat),
        .wb_ack_o      (wb_ack),
        .wb_err_o      (wb_err),
        .hart_i        (hart),
        .fault_valid_o (fault_valid),
        .fault_adr_o   (fault_adr),
        .fault_hart_o  (fault_hart),
        .fault_cnt_o   (fault_cnt)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Table and model helpers.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic add_op(string name, logic we, ptag_t tag, logic [ADR_WIDTH-1:0] adr,
                          hart_id_t hid, hart_mask_t mask, logic exp_err);
        op_name.push_back(name);
        op_we.push_back(we);
        op_tag.push_back(tag);
        op_adr.push_back(adr);
        op_hart.push_back(hid);
        op_mask.push_back(mask);
        op_err.push_back(exp_err);
    endtask

    `include "tb_mtag_table.svh"

    // Tag on top, unused middle bits zero, byte address at the bottom.
    function automatic xlen_t make_ptr(ptag_t tag, logic [ADR_WIDTH-1:0] adr);
        return {tag, {(XLEN - PTAG_WIDTH - ADR_WIDTH){1'b0}}, adr};
    endfunction

    function automatic logic [TADR_WIDTH-1:0] granule_of(logic [ADR_WIDTH-1:0] adr);
        return adr[ADR_WIDTH-1:GRANULARITY];
    endfunction

    // ERR when the hart does not own the granule or the tags differ.
    function automatic logic rule_err(tag_entry_t ent, ptag_t tag, hart_id_t hid);
        return !ent.harts[hid] || (ent.tag != tag);
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Compare tasks.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("MISMATCH %s: expected %b, actual %b", name, exp, act);
            mismatch_cnt++;
        end
    endtask

    task automatic check_ptr(string name, xlen_t exp, xlen_t act);
        if (act !== exp) begin
            $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
            mismatch_cnt++;
        end
    endtask

    task automatic check_hart(string name, hart_id_t exp, hart_id_t act);
        if (act !== exp) begin
            $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
            mismatch_cnt++;
        end
    endtask

    task automatic check_count(string name, logic [7:0] exp, logic [7:0] act);
        if (act !== exp) begin
            $display("MISMATCH %s: expected %0d, actual %0d", name, exp, act);
            mismatch_cnt++;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // One bus access.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // With hold set, STB stays high through the cycle after ACK or ERR.
    task automatic run_access(string name, logic we, ptag_t tag, logic [ADR_WIDTH-1:0] adr,
                              hart_id_t hid, hart_mask_t mask, logic exp_err, logic hold);
        xlen_t ptr;
        int    edges;
        logic  got;
        ptr = make_ptr(tag, adr);
        @(negedge clk);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = we;
        wb_adr = ptr;
        wb_dat = {{(XLEN - HARTS){1'b0}}, mask};
        hart   = hid;
        if (we) begin
            model_mem[granule_of(adr)].tag   = tag;
            model_mem[granule_of(adr)].harts = mask;
        end
        if (exp_err) begin
            exp_faults++;
            if (!have_fault) begin
                have_fault = 1'b1;
                first_ptr  = ptr;
                first_hart = hid;
            end
        end
        edges = 0;
        got   = 1'b0;
        // Acceptance edge, the unit is idle here.
        @(posedge clk);
        while (!got && edges < RESP_LIMIT) begin
            @(posedge clk);
            edges++;
            @(negedge clk);
            got = wb_ack || wb_err;
        end
        if (!got) begin
            $display("ERROR %s: no ACK or ERR within %0d cycles", name, RESP_LIMIT);
            other_cnt++;
        end else begin
            check_count({name, " latency"}, 8'd2, 8'(edges));
            check_bit({name, " err"}, exp_err, wb_err);
            check_bit({name, " ack"}, !exp_err, wb_ack);
        end
        if (hold) begin
            @(negedge clk);
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        // A held STB must not have started a second access.
        repeat (2) begin
            @(negedge clk);
            if (wb_ack || wb_err) begin
                $display("ERROR %s: ACK or ERR seen with no new request", name);
                other_cnt++;
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Clock, watchdog and test sequence.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Eight cycles per access plus reset, doubled.
    initial begin
        int limit;
        wait (table_ready);
        limit = ((op_name.size() + 2 * N_RAND) * 8 + 3) * 2;
        repeat (limit) @(posedge clk);
        $display("Timeout: the run was still going after %0d cycles", limit);
        $display("Checks failed");
        $finish;
    end

    initial begin
        integer               i;
        logic [31:0]          r_st;
        logic [31:0]          r_tag;
        logic [31:0]          r_chk;
        ptag_t                st_tag;
        logic [ADR_WIDTH-1:0] st_adr;
        ptag_t                chk_tag;
        logic [ADR_WIDTH-1:0] chk_adr;
        hart_id_t             chk_hart;
        logic                 exp;
        rst    = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        wb_adr = '0;
        wb_dat = '0;
        hart   = '0;
        build_table();
        table_ready = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Outputs after reset.
        check_bit("reset ack", 1'b0, wb_ack);
        check_bit("reset err", 1'b0, wb_err);
        check_bit("reset fault_valid", 1'b0, fault_valid);
        check_count("reset fault_cnt", 8'd0, fault_cnt);

        // Directed table, STB held on every second entry.
        for (i = 0; i < op_name.size(); i++) begin
            run_access(op_name[i], op_we[i], op_tag[i], op_adr[i], op_hart[i],
                       op_mask[i], op_err[i], i[0]);
        end

        // Random store, then a check inside the same granule.
        for (i = 0; i < N_RAND; i++) begin
            r_st    = $random(seed);
            r_tag   = $random(seed);
            r_chk   = $random(seed);
            st_tag  = r_tag[PTAG_WIDTH-1:0];
            st_adr  = r_st[ADR_WIDTH-1:0];
            run_access($sformatf("rnd_store_%0d", i), 1'b1, st_tag, st_adr,
                       r_st[16 +: HART_ID_WIDTH], r_st[ADR_WIDTH +: HARTS], 1'b0, 1'b0);
            // Half the checks reuse the stored tag.
            chk_tag  = r_chk[31] ? st_tag : r_chk[PTAG_WIDTH-1:0];
            chk_adr  = {granule_of(st_adr), r_chk[20 +: GRANULARITY]};
            chk_hart = r_chk[24 +: HART_ID_WIDTH];
            exp      = rule_err(model_mem[granule_of(chk_adr)], chk_tag, chk_hart);
            run_access($sformatf("rnd_check_%0d", i), 1'b0, chk_tag, chk_adr,
                       chk_hart, '0, exp, r_chk[28]);
        end

        // Fault record holds the first fault and counts all of them.
        check_bit("fault_valid", have_fault, fault_valid);
        check_ptr("fault_adr", first_ptr, fault_adr);
        check_hart("fault_hart", first_hart, fault_hart);
        check_count("fault_cnt", 8'(exp_faults), fault_cnt);

        $display("Error counts: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+.
mtag_pkg.sv
mtag_decode.sv
mtag_chk.sv
mtag_store.sv
mtag_result.sv
mtag_unit.sv
tb_mtag_unit.sv

// File: Makefile
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -j 0
TOP        ?= tb_mtag_unit
FILELIST   ?= tb.f
OBJ_DIR    ?= obj_dir
PASS_MSG   := All checks passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
